//--- hero_pkg.sv
////////////////////////////////////////////////////////////
// shared widths and L2 base address, bus request/response
// structs, RAB slice configuration, bus and cluster states
////////////////////////////////////////////////////////////

`default_nettype none

package hero_pkg;

  localparam int unsigned AW        = 32;
  localparam int unsigned DW        = 32;
  localparam int unsigned PAGE_BITS = 12;

  // start of the L2 window, everything else goes to the RAB
  localparam logic [AW-1:0] L2_BASE = 32'h1C00_0000;

  // single-word request, held as a level until answered
  typedef struct packed {
    logic          valid;
    logic          we;
    logic [AW-1:0] addr;
    logic [DW-1:0] wdata;
  } mem_req_t;

  // valid is a one-cycle pulse
  typedef struct packed {
    logic          valid;
    logic          err;
    logic [DW-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                    we;
    logic [1:0]              idx;
    logic [AW-PAGE_BITS-1:0] va_page;
    logic [AW-PAGE_BITS-1:0] pa_page;
  } rab_conf_t;

  typedef enum logic {
    BUS_IDLE,
    BUS_WAIT
  } bus_state_e;

  typedef enum logic [1:0] {
    CL_IDLE,
    CL_READ,
    CL_WRITE,
    CL_DONE
  } cl_state_e;

endpackage

`default_nettype wire

//--- pulp_cluster.sv
////////////////////////////////////////////////////////////
// compute cluster: sums a block of L2 words and writes the
// result to the host result area through the RAB
////////////////////////////////////////////////////////////

`default_nettype none

module pulp_cluster #(
  parameter int unsigned             CLUSTER_ID  = 0,
  parameter int unsigned             N_WORDS     = 4,
  parameter logic [hero_pkg::AW-1:0] RES_VA_BASE = 32'h8000_0000
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               fetch_en_i,
  output logic               eoc_o,
  output logic               busy_o,
  output hero_pkg::mem_req_t req_o,
  input  hero_pkg::mem_rsp_t rsp_i
);
  import hero_pkg::*;

  localparam int unsigned   CNT_W   = (N_WORDS > 1) ? $clog2(N_WORDS) : 1;
  localparam logic [AW-1:0] RD_BASE = L2_BASE + AW'(CLUSTER_ID * N_WORDS * 4);
  localparam logic [AW-1:0] WR_ADDR = RES_VA_BASE + AW'(CLUSTER_ID * 4);

  cl_state_e        state_q, state_d;
  logic [CNT_W-1:0] cnt_q;
  logic [DW-1:0]    sum_q;
  logic             last_word;

  assign last_word = (cnt_q == CNT_W'(N_WORDS - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      CL_IDLE: begin
        // start strobes only count while idle
        if (fetch_en_i) begin
          state_d = CL_READ;
        end
      end
      CL_READ: begin
        if (rsp_i.valid && last_word) begin
          state_d = CL_WRITE;
        end
      end
      CL_WRITE: begin
        if (rsp_i.valid) begin
          state_d = CL_DONE;
        end
      end
      default: state_d = CL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= CL_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == CL_IDLE) begin
        cnt_q <= '0;
      end else if (state_q == CL_READ && rsp_i.valid) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // accumulate modulo 2^32 and drop the sum if the host write fails
  always_ff @(posedge clk_i) begin
    if (state_q == CL_IDLE) begin
      sum_q <= '0;
    end else if (state_q == CL_READ && rsp_i.valid) begin
      sum_q <= sum_q + rsp_i.rdata;
    end else if (state_q == CL_WRITE && rsp_i.valid && rsp_i.err) begin
      sum_q <= '0;
    end
  end

  assign busy_o = (state_q == CL_READ) || (state_q == CL_WRITE);
  assign eoc_o  = (state_q == CL_DONE);

  always_comb begin
    req_o.valid = busy_o;
    req_o.we    = (state_q == CL_WRITE);
    req_o.addr  = (state_q == CL_WRITE) ? WR_ADDR : RD_BASE + (AW'(cnt_q) << 2);
    req_o.wdata = sum_q;
  end

  // a response only comes back while this cluster is requesting
  a_rsp_when_busy: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_i.valid |-> busy_o
  );

endmodule

`default_nettype wire

//--- soc_bus.sv
////////////////////////////////////////////////////////////
// system bus: round-robin arbiter over clusters and host,
// L2 / RAB address decode, one transfer in flight
////////////////////////////////////////////////////////////

`default_nettype none

module soc_bus #(
  parameter int unsigned N_CLUSTERS = 4,
  parameter int unsigned L2_WORDS   = 64
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  hero_pkg::mem_req_t [N_CLUSTERS:0] mst_req_i,
  output hero_pkg::mem_rsp_t [N_CLUSTERS:0] mst_rsp_o,
  output hero_pkg::mem_req_t                 l2_req_o,
  input  hero_pkg::mem_rsp_t                 l2_rsp_i,
  output hero_pkg::mem_req_t                 rab_req_o,
  input  hero_pkg::mem_rsp_t                 rab_rsp_i
);
  import hero_pkg::*;

  localparam int unsigned   N_MST  = N_CLUSTERS + 1;
  localparam int unsigned   IDX_W  = (N_MST > 1) ? $clog2(N_MST) : 1;
  localparam logic [AW-1:0] L2_END = L2_BASE + AW'(L2_WORDS * 4);

  bus_state_e       state_q;
  logic [IDX_W-1:0] rr_q;
  logic [IDX_W-1:0] gnt_q;
  logic [IDX_W-1:0] gnt_idx;
  logic             gnt_found;
  mem_req_t         sel_req;
  logic             sel_l2;
  mem_req_t         tgt_req_q;
  logic             tgt_vld_q;
  logic             tgt_l2_q;
  mem_rsp_t         tgt_rsp;
  logic             rsp_done;

  // first requester at or after the round-robin pointer
  always_comb begin
    int unsigned idx;
    gnt_found = 1'b0;
    gnt_idx   = '0;
    for (int unsigned k = 0; k < N_MST; k++) begin
      idx = (32'(rr_q) + k) % N_MST;
      if (!gnt_found && mst_req_i[idx].valid) begin
        gnt_found = 1'b1;
        gnt_idx   = IDX_W'(idx);
      end
    end
  end

  assign sel_req = mst_req_i[gnt_idx];
  assign sel_l2  = (sel_req.addr >= L2_BASE) && (sel_req.addr < L2_END);

  assign tgt_rsp  = tgt_l2_q ? l2_rsp_i : rab_rsp_i;
  assign rsp_done = (state_q == BUS_WAIT) && tgt_rsp.valid;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= BUS_IDLE;
      rr_q      <= '0;
      gnt_q     <= '0;
      tgt_vld_q <= 1'b0;
      tgt_l2_q  <= 1'b0;
    end else begin
      case (state_q)
        BUS_IDLE: begin
          if (gnt_found) begin
            state_q   <= BUS_WAIT;
            gnt_q     <= gnt_idx;
            rr_q      <= (gnt_idx == IDX_W'(N_MST - 1)) ? '0 : gnt_idx + 1'b1;
            tgt_vld_q <= 1'b1;
            tgt_l2_q  <= sel_l2;
          end
        end
        default: begin
          if (rsp_done) begin
            state_q   <= BUS_IDLE;
            tgt_vld_q <= 1'b0;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == BUS_IDLE && gnt_found) begin
      tgt_req_q <= sel_req;
    end
  end

  always_comb begin
    l2_req_o        = tgt_req_q;
    l2_req_o.valid  = tgt_vld_q && tgt_l2_q;
    rab_req_o       = tgt_req_q;
    rab_req_o.valid = tgt_vld_q && !tgt_l2_q;
  end

  // response goes back to the granted master only
  always_comb begin
    for (int unsigned m = 0; m < N_MST; m++) begin
      mst_rsp_o[m]       = tgt_rsp;
      mst_rsp_o[m].valid = rsp_done && (gnt_q == IDX_W'(m));
    end
  end

  // only the addressed target answers, and only while a transfer is open
  a_rsp_from_target: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (l2_rsp_i.valid || rab_rsp_i.valid) |-> rsp_done
  );

  // the granted master keeps its request level until answered
  a_gnt_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (state_q == BUS_WAIT) |-> mst_req_i[gnt_q].valid
  );

endmodule

`default_nettype wire

//--- l2_mem.sv
////////////////////////////////////////////////////////////
// shared L2 memory, word addressed, registered response
////////////////////////////////////////////////////////////

`default_nettype none

module l2_mem #(
  parameter int unsigned L2_WORDS = 64
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  hero_pkg::mem_req_t req_i,
  output hero_pkg::mem_rsp_t rsp_o
);
  import hero_pkg::*;

  localparam int unsigned IDX_W = (L2_WORDS > 1) ? $clog2(L2_WORDS) : 1;

  logic [DW-1:0]    mem_q [L2_WORDS];
  logic [IDX_W-1:0] idx;
  logic             fire;
  logic             busy_q;
  logic             rsp_vld_q;
  logic [DW-1:0]    rdata_q;

  // upper address bits are dropped, so the index wraps
  assign idx  = req_i.addr[IDX_W+1:2];
  // answer a held request once
  assign fire = req_i.valid && !busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      rsp_vld_q <= 1'b0;
    end else begin
      busy_q    <= req_i.valid;
      rsp_vld_q <= fire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      if (req_i.we) begin
        mem_q[idx] <= req_i.wdata;
        rdata_q    <= '0;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  always_comb begin
    rsp_o.valid = rsp_vld_q;
    rsp_o.err   = 1'b0;
    rsp_o.rdata = rdata_q;
  end

endmodule

`default_nettype wire

//--- rab.sv
////////////////////////////////////////////////////////////
// remapping address block: slice table with config port,
// page translation toward host DRAM, miss response and irq
////////////////////////////////////////////////////////////

`default_nettype none

module rab #(
  parameter int unsigned NUM_SLICES = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  hero_pkg::rab_conf_t conf_i,
  input  hero_pkg::mem_req_t  req_i,
  output hero_pkg::mem_rsp_t  rsp_o,
  output hero_pkg::mem_req_t  dram_req_o,
  input  hero_pkg::mem_rsp_t  dram_rsp_i,
  output logic                miss_irq_o
);
  import hero_pkg::*;

  localparam int unsigned PG_W = AW - PAGE_BITS;

  logic [NUM_SLICES-1:0] slc_vld_q;
  logic [PG_W-1:0]       slc_va_q [NUM_SLICES];
  logic [PG_W-1:0]       slc_pa_q [NUM_SLICES];
  logic                  hit;
  logic [PG_W-1:0]       hit_pa;
  logic                  fire;
  logic                  busy_q;
  logic                  miss_q;
  logic                  dram_vld_q;
  mem_req_t              dram_req_q;

  // slices only become invalid again through reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slc_vld_q <= '0;
    end else begin
      for (int i = 0; i < NUM_SLICES; i++) begin
        if (conf_i.we && int'(conf_i.idx) == i) begin
          slc_vld_q[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_SLICES; i++) begin
      if (conf_i.we && int'(conf_i.idx) == i) begin
        slc_va_q[i] <= conf_i.va_page;
        slc_pa_q[i] <= conf_i.pa_page;
      end
    end
  end

  // walk down so the lowest matching slice is the last to write
  always_comb begin
    hit    = 1'b0;
    hit_pa = '0;
    for (int i = NUM_SLICES - 1; i >= 0; i--) begin
      if (slc_vld_q[i] && slc_va_q[i] == req_i.addr[AW-1:PAGE_BITS]) begin
        hit    = 1'b1;
        hit_pa = slc_pa_q[i];
      end
    end
  end

  assign fire = req_i.valid && !busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      miss_q     <= 1'b0;
      dram_vld_q <= 1'b0;
    end else begin
      busy_q <= req_i.valid;
      miss_q <= fire && !hit;
      if (fire && hit) begin
        dram_vld_q <= 1'b1;
      end else if (dram_rsp_i.valid) begin
        dram_vld_q <= 1'b0;
      end
    end
  end

  // page swapped, offset kept
  always_ff @(posedge clk_i) begin
    if (fire && hit) begin
      dram_req_q      <= req_i;
      dram_req_q.addr <= {hit_pa, req_i.addr[PAGE_BITS-1:0]};
    end
  end

  always_comb begin
    dram_req_o       = dram_req_q;
    dram_req_o.valid = dram_vld_q;
    rsp_o.valid      = miss_q || (dram_vld_q && dram_rsp_i.valid);
    rsp_o.err        = miss_q;
    rsp_o.rdata      = miss_q ? '0 : dram_rsp_i.rdata;
  end

  assign miss_irq_o = miss_q;

  // a miss answers with err and never overlaps a DRAM transfer
  a_miss_err: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    miss_irq_o |-> (rsp_o.err && !dram_req_o.valid)
  );

endmodule

`default_nettype wire

//--- hero.sv
////////////////////////////////////////////////////////////
// top level: clusters, system bus, L2 memory and RAB
////////////////////////////////////////////////////////////

`default_nettype none

module hero #(
  parameter int unsigned             N_CLUSTERS  = 4,
  parameter int unsigned             N_WORDS     = 4,
  parameter int unsigned             L2_WORDS    = 64,
  parameter int unsigned             NUM_SLICES  = 4,
  parameter logic [hero_pkg::AW-1:0] RES_VA_BASE = 32'h8000_0000
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [N_CLUSTERS-1:0] cl_fetch_en_i,
  output logic [N_CLUSTERS-1:0] cl_eoc_o,
  output logic [N_CLUSTERS-1:0] cl_busy_o,
  input  hero_pkg::mem_req_t    host_req_i,
  output hero_pkg::mem_rsp_t    host_rsp_o,
  input  hero_pkg::rab_conf_t   rab_conf_i,
  output hero_pkg::mem_req_t    dram_req_o,
  input  hero_pkg::mem_rsp_t    dram_rsp_i,
  output logic                  rab_miss_irq_o
);
  import hero_pkg::*;

  mem_req_t [N_CLUSTERS-1:0] cl_req;
  mem_rsp_t [N_CLUSTERS-1:0] cl_rsp;
  mem_req_t [N_CLUSTERS:0]   mst_req;
  mem_rsp_t [N_CLUSTERS:0]   mst_rsp;
  mem_req_t                  l2_req;
  mem_rsp_t                  l2_rsp;
  mem_req_t                  rab_req;
  mem_rsp_t                  rab_rsp;

  // host port takes the top master index
  assign mst_req    = {host_req_i, cl_req};
  assign cl_rsp     = mst_rsp[N_CLUSTERS-1:0];
  assign host_rsp_o = mst_rsp[N_CLUSTERS];

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : gen_clusters
    pulp_cluster #(
      .CLUSTER_ID  (i),
      .N_WORDS     (N_WORDS),
      .RES_VA_BASE (RES_VA_BASE)
    ) i_cluster (
      .clk_i,
      .rst_n_i,
      .fetch_en_i (cl_fetch_en_i[i]),
      .eoc_o      (cl_eoc_o[i]),
      .busy_o     (cl_busy_o[i]),
      .req_o      (cl_req[i]),
      .rsp_i      (cl_rsp[i])
    );
  end

  soc_bus #(
    .N_CLUSTERS (N_CLUSTERS),
    .L2_WORDS   (L2_WORDS)
  ) i_soc_bus (
    .clk_i,
    .rst_n_i,
    .mst_req_i (mst_req),
    .mst_rsp_o (mst_rsp),
    .l2_req_o  (l2_req),
    .l2_rsp_i  (l2_rsp),
    .rab_req_o (rab_req),
    .rab_rsp_i (rab_rsp)
  );

  l2_mem #(
    .L2_WORDS (L2_WORDS)
  ) i_l2_mem (
    .clk_i,
    .rst_n_i,
    .req_i (l2_req),
    .rsp_o (l2_rsp)
  );

  rab #(
    .NUM_SLICES (NUM_SLICES)
  ) i_rab (
    .clk_i,
    .rst_n_i,
    .conf_i     (rab_conf_i),
    .req_i      (rab_req),
    .rsp_o      (rab_rsp),
    .dram_req_o,
    .dram_rsp_i,
    .miss_irq_o (rab_miss_irq_o)
  );

endmodule

`default_nettype wire

//--- tb_hero.sv
////////////////////////////////////////////////////////////
// testbench for hero: replays testdata records, models the
// host DRAM, checks L2 access, sums, remapping and misses
////////////////////////////////////////////////////////////

`default_nettype none

module tb_hero;
  import hero_pkg::*;

  localparam int unsigned N_CL = 4;

  logic            clk;
  logic            rst_n;
  logic [N_CL-1:0] cl_fetch_en;
  logic [N_CL-1:0] cl_eoc;
  logic [N_CL-1:0] cl_busy;
  mem_req_t        host_req;
  mem_rsp_t        host_rsp;
  rab_conf_t       rab_conf;
  mem_req_t        dram_req;
  mem_rsp_t        dram_rsp;
  logic            miss_irq;

  int          n_rec;
  int          n_tests;
  int          n_fail;
  int          miss_total;
  int          miss_base;
  int          log_base;
  logic [31:0] rnd;
  logic        rand_dly;
  logic [31:0] log_addr [$];
  logic [31:0] log_data [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];

  hero #(
    .N_CLUSTERS  (N_CL),
    .N_WORDS     (4),
    .L2_WORDS    (64),
    .NUM_SLICES  (4),
    .RES_VA_BASE (32'h8000_0000)
  ) uut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .cl_fetch_en_i  (cl_fetch_en),
    .cl_eoc_o       (cl_eoc),
    .cl_busy_o      (cl_busy),
    .host_req_i     (host_req),
    .host_rsp_o     (host_rsp),
    .rab_conf_i     (rab_conf),
    .dram_req_o     (dram_req),
    .dram_rsp_i     (dram_rsp),
    .rab_miss_irq_o (miss_irq)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // host DRAM, logs every write it answers
  initial begin : dram_model
    int unsigned dly;
    mem_req_t    req;
    dram_rsp = '0;
    rnd      = 32'hbc2db4dd;
    forever begin
      @(negedge clk);
      if (dram_req.valid) begin
        req = dram_req;
        dly = 2;
        if (rand_dly) begin
          rnd = lcg_next(rnd);
          dly = 1 + int'(rnd[17:16]);
        end
        repeat (dly) @(posedge clk);
        #1;
        dram_rsp.valid = 1'b1;
        if (req.we) begin
          log_addr.push_back(req.addr);
          log_data.push_back(req.wdata);
        end
        @(posedge clk);
        #1;
        dram_rsp.valid = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      miss_total <= 0;
    end else if (miss_irq) begin
      miss_total <= miss_total + 1;
    end
  end

  initial begin : watchdog
    wait (n_rec != 0);
    repeat (200 * n_rec + 1000) @(posedge clk);
    $display("timeout: run did not end within %0d cycles", 200 * n_rec + 1000);
    $display("Simulation finished: FAIL");
    $finish;
  end

  task automatic report(input string name, input int errs);
    n_tests++;
    if (errs == 0) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      n_fail++;
      $display("test %0d %s: %0d errors", n_tests, name, errs);
    end
  endtask

  // one host transfer, request held until the response pulse
  task automatic host_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, output mem_rsp_t rsp);
    @(posedge clk);
    #1;
    host_req.valid = 1'b1;
    host_req.we    = we;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    @(negedge clk);
    while (!host_rsp.valid) @(negedge clk);
    rsp = host_rsp;
    @(posedge clk);
    #1;
    host_req.valid = 1'b0;
  endtask

  task automatic host_check(input logic [31:0] addr, input logic [31:0] data);
    mem_rsp_t rsp;
    int       errs;
    errs = 0;
    host_access(1'b1, addr, data, rsp);
    host_access(1'b0, addr, '0, rsp);
    if (rsp.rdata !== data) begin
      $display("Mismatch host_rsp_o.rdata at %h: expected %h, got %h", addr, data, rsp.rdata);
      errs++;
    end
    if (rsp.err !== 1'b0) begin
      $display("Mismatch host_rsp_o.err at %h: expected 0, got %h", addr, rsp.err);
      errs++;
    end
    report("host L2 access", errs);
  endtask

  task automatic program_slice(input logic [1:0] idx, input logic [39:0] pages);
    @(posedge clk);
    #1;
    rab_conf.we      = 1'b1;
    rab_conf.idx     = idx;
    rab_conf.va_page = pages[39:20];
    rab_conf.pa_page = pages[19:0];
    @(posedge clk);
    #1;
    rab_conf.we = 1'b0;
  endtask

  task automatic pulse_fetch(input logic [N_CL-1:0] mask);
    @(posedge clk);
    #1;
    cl_fetch_en = mask;
    @(posedge clk);
    #1;
    cl_fetch_en = '0;
  endtask

  // start, optionally strobe again while busy, wait for every eoc
  task automatic run_clusters(input logic [N_CL-1:0] mask, input logic again);
    logic [N_CL-1:0] eoc_seen;
    eoc_seen  = '0;
    rand_dly  = (mask == '1);
    log_base  = log_addr.size();
    miss_base = miss_total;
    exp_addr.delete();
    exp_data.delete();
    pulse_fetch(mask);
    if (again) begin
      repeat (2) @(posedge clk);
      pulse_fetch(mask);
    end
    while ((eoc_seen & mask) != mask || (cl_busy & mask) != '0) begin
      @(negedge clk);
      eoc_seen = eoc_seen | cl_eoc;
    end
    // leave room for a stray second write
    repeat (40) @(posedge clk);
  endtask

  task automatic check_run(input int exp_miss);
    int errs;
    int hit;
    bit used [$];
    errs = 0;
    for (int i = log_base; i < log_addr.size(); i++) begin
      used.push_back(1'b0);
    end
    for (int e = 0; e < exp_addr.size(); e++) begin
      hit = -1;
      for (int i = 0; i < used.size(); i++) begin
        if (hit < 0 && !used[i] && log_addr[log_base + i] == exp_addr[e]) begin
          hit = i;
        end
      end
      if (hit < 0) begin
        $display("no DRAM write arrived at address %h", exp_addr[e]);
        errs++;
      end else begin
        used[hit] = 1'b1;
        if (log_data[log_base + hit] != exp_data[e]) begin
          $display("Mismatch dram_req_o.wdata at %h: expected %h, got %h",
                   exp_addr[e], exp_data[e], log_data[log_base + hit]);
          errs++;
        end
      end
    end
    for (int i = 0; i < used.size(); i++) begin
      if (!used[i]) begin
        $display("unexpected DRAM write to %h with data %h",
                 log_addr[log_base + i], log_data[log_base + i]);
        errs++;
      end
    end
    if (miss_total - miss_base != exp_miss) begin
      $display("Mismatch rab_miss_irq_o pulses: expected %h, got %h",
               exp_miss, miss_total - miss_base);
      errs++;
    end
    report("cluster run", errs);
  endtask

  initial begin : main
    int          fd;
    int          tag;
    string       line;
    logic [63:0] va;
    logic [63:0] vb;
    int          rec_tag [$];
    logic [63:0] rec_a [$];
    logic [63:0] rec_b [$];
    rst_n       = 1'b0;
    cl_fetch_en = '0;
    host_req    = '0;
    rab_conf    = '0;
    rand_dly    = 1'b0;
    n_rec       = 0;
    n_tests     = 0;
    n_fail      = 0;
    fd = $fopen("hero_testdata.hex", "r");
    if (fd == 0) begin
      $display("could not open hero_testdata.hex");
      n_fail++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && $sscanf(line, "%h %h %h", tag, va, vb) == 3) begin
          rec_tag.push_back(tag);
          rec_a.push_back(va);
          rec_b.push_back(vb);
        end
      end
      $fclose(fd);
      if (rec_tag.size() == 0) begin
        $display("no records found in hero_testdata.hex");
        n_fail++;
      end
    end
    n_rec = rec_tag.size();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int r = 0; r < rec_tag.size(); r++) begin
      va = rec_a[r];
      vb = rec_b[r];
      case (rec_tag[r])
        0: program_slice(va[1:0], vb[39:0]);
        1: host_check(va[31:0], vb[31:0]);
        2: run_clusters(va[N_CL-1:0], vb[0]);
        3: begin
          exp_addr.push_back(va[31:0]);
          exp_data.push_back(vb[31:0]);
        end
        4: check_run(int'(va[31:0]));
        default: begin
          $display("unknown record tag %0d in record %0d", rec_tag[r], r);
          n_fail++;
        end
      endcase
    end
    $display("tests: %0d, passed: %0d, failed: %0d", n_tests, n_tests - n_fail, n_fail);
    if (n_fail == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hero_testdata.hex
// tag a b: 0 slice index / {va page, pa page}, 1 L2 address / data, 2 start mask / restart
// 3 DRAM address / data, 4 miss count / unused; all values hex
1 1c000000 00000011
1 1c000004 00000022
1 1c000008 00000033
1 1c00000c 00000044
1 1c000010 ffffffff
1 1c000014 00000002
1 1c000018 00000003
1 1c00001c 00000004
1 1c000020 12345678
1 1c000024 11111111
1 1c000028 22222222
1 1c00002c 33333333
1 1c000030 a0000000
1 1c000034 a0000000
1 1c000038 00000abc
1 1c00003c 00000001
0 0 8000000100
2 1 0
3 00100000 000000aa
4 0 0
2 f 0
3 00100000 000000aa
3 00100004 00000008
3 00100008 789abcde
3 0010000c 40000abd
4 0 0
0 0 8000000200
2 2 0
3 00200004 00000008
4 0 0
0 1 8000000300
2 4 0
3 00200008 789abcde
4 0 0
2 8 1
3 0020000c 40000abd
4 0 0
0 0 9000000400
0 1 9000000500
2 3 0
4 2 0

//--- flist.f
hero_pkg.sv
pulp_cluster.sv
soc_bus.sv
l2_mem.sv
rab.sv
hero.sv
tb_hero.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the hero testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_hero -f flist.f -o tb_hero_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_hero_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
